// File: bus_port.sv
`timescale 1ns/1ps

module bus_port (
	input  logic               clk_i,
	input  logic               arst_n_i,
	// Core side
	input  logic               req_i,
	output logic               ack_o,
	input  node_pkg::bus_req_t bus_i,
	output node_pkg::bus_rsp_t rsp_o,
	// Toward the decoder
	output logic               cmd_valid_o,
	output node_pkg::bus_req_t cmd_o,
	input  logic               rsp_valid_i,
	input  node_pkg::bus_rsp_t rsp_i
);

	node_pkg::port_state_t state_q;
	logic                  req_q; // req_i as seen at the previous edge
	logic                  start; // A new access is taken this cycle

	// A request is accepted one edge after req_i is first seen high
	assign start = (state_q == node_pkg::IDLE) && req_q && req_i;

	// ==============================
	// Handshake FSM
	// ==============================

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= node_pkg::IDLE;
			req_q       <= 1'b0;
			ack_o       <= 1'b0;
			cmd_valid_o <= 1'b0;
			rsp_o       <= '0;
		end else begin
			req_q       <= req_i; // Port capture stage
			cmd_valid_o <= 1'b0; // Single cycle pulse by default
			case (state_q)
				node_pkg::IDLE: begin
					if (start) begin
						cmd_valid_o <= 1'b1; // Hand the access downstream
						state_q     <= node_pkg::BUSY;
					end
				end
				node_pkg::BUSY: begin
					if (rsp_valid_i) begin
						rsp_o   <= rsp_i; // Held for the whole ack phase
						ack_o   <= 1'b1;
						state_q <= node_pkg::ACK;
					end
				end
				node_pkg::ACK: begin
					// The core keeps the response by holding req high
					if (!req_i) begin
						ack_o   <= 1'b0;
						state_q <= node_pkg::IDLE;
					end
				end
				default: begin
					ack_o   <= 1'b0;
					state_q <= node_pkg::IDLE;
				end
			endcase
		end
	end

	// Request payload is latched once per access
	always_ff @(posedge clk_i) begin
		if (start) begin
			cmd_o <= bus_i;
		end
	end

endmodule

// File: mem_node.sv
`timescale 1ns/1ps

module mem_node #(
	parameter int SHARED_AW  = 15,
	parameter int SCRATCH_AW = 13
) (
	input  logic               clk_i,
	input  logic               arst_n_i,
	// Core 0 port
	input  logic               core0_req_i,
	output logic               core0_ack_o,
	input  node_pkg::bus_req_t core0_bus_i,
	output node_pkg::bus_rsp_t core0_rsp_o,
	// Core 1 port
	input  logic               core1_req_i,
	output logic               core1_ack_o,
	input  node_pkg::bus_req_t core1_bus_i,
	output node_pkg::bus_rsp_t core1_rsp_o
);

	// Per core links, index 0 is core 0
	logic               cmd_valid [2];
	node_pkg::bus_req_t cmd [2];
	logic               rsp_valid [2];
	node_pkg::bus_rsp_t rsp [2];
	logic               sh_valid [2]; // Strobe into the shared RAM
	logic               sp_valid [2]; // Strobe into the scratchpad
	node_pkg::mem_cmd_t mem_cmd [2];
	logic               sh_rd_valid [2];
	node_pkg::data_t    sh_rd [2];
	logic               sp_rd_valid [2];
	node_pkg::data_t    sp_rd [2];

	// ==============================
	// Core 0 path
	// ==============================

	bus_port port0 (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.req_i(core0_req_i), .ack_o(core0_ack_o),
		.bus_i(core0_bus_i), .rsp_o(core0_rsp_o),
		.cmd_valid_o(cmd_valid[0]), .cmd_o(cmd[0]),
		.rsp_valid_i(rsp_valid[0]), .rsp_i(rsp[0])
	);

	region_decode #(.SHARED_AW(SHARED_AW), .SCRATCH_AW(SCRATCH_AW)) dec0 (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.cmd_valid_i(cmd_valid[0]), .cmd_i(cmd[0]),
		.shared_valid_o(sh_valid[0]), .scratch_valid_o(sp_valid[0]),
		.mem_cmd_o(mem_cmd[0]),
		.shared_rd_valid_i(sh_rd_valid[0]), .shared_rd_i(sh_rd[0]),
		.scratch_rd_valid_i(sp_rd_valid[0]), .scratch_rd_i(sp_rd[0]),
		.rsp_valid_o(rsp_valid[0]), .rsp_o(rsp[0])
	);

	scratch_ram #(.SCRATCH_AW(SCRATCH_AW)) spad0 (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.valid_i(sp_valid[0]), .cmd_i(mem_cmd[0]),
		.rd_valid_o(sp_rd_valid[0]), .rd_o(sp_rd[0])
	);

	// ==============================
	// Core 1 path
	// ==============================

	bus_port port1 (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.req_i(core1_req_i), .ack_o(core1_ack_o),
		.bus_i(core1_bus_i), .rsp_o(core1_rsp_o),
		.cmd_valid_o(cmd_valid[1]), .cmd_o(cmd[1]),
		.rsp_valid_i(rsp_valid[1]), .rsp_i(rsp[1])
	);

	region_decode #(.SHARED_AW(SHARED_AW), .SCRATCH_AW(SCRATCH_AW)) dec1 (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.cmd_valid_i(cmd_valid[1]), .cmd_i(cmd[1]),
		.shared_valid_o(sh_valid[1]), .scratch_valid_o(sp_valid[1]),
		.mem_cmd_o(mem_cmd[1]),
		.shared_rd_valid_i(sh_rd_valid[1]), .shared_rd_i(sh_rd[1]),
		.scratch_rd_valid_i(sp_rd_valid[1]), .scratch_rd_i(sp_rd[1]),
		.rsp_valid_o(rsp_valid[1]), .rsp_o(rsp[1])
	);

	scratch_ram #(.SCRATCH_AW(SCRATCH_AW)) spad1 (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.valid_i(sp_valid[1]), .cmd_i(mem_cmd[1]),
		.rd_valid_o(sp_rd_valid[1]), .rd_o(sp_rd[1])
	);

	// Shared RAM sits between both paths, port a wins write collisions
	shared_ram #(.SHARED_AW(SHARED_AW)) shram (
		.clk_i(clk_i), .arst_n_i(arst_n_i),
		.a_valid_i(sh_valid[0]), .a_cmd_i(mem_cmd[0]), // Core 0
		.a_rd_valid_o(sh_rd_valid[0]), .a_rd_o(sh_rd[0]),
		.b_valid_i(sh_valid[1]), .b_cmd_i(mem_cmd[1]), // Core 1
		.b_rd_valid_o(sh_rd_valid[1]), .b_rd_o(sh_rd[1])
	);

endmodule

// File: mem_node_properties.sv
`timescale 1ns/1ps

module mem_node_properties (
	input logic               clk_i,
	input logic               arst_n_i,
	input logic               core0_req_i,
	input logic               core0_ack_i,
	input node_pkg::bus_rsp_t core0_rsp_i,
	input logic               core1_req_i,
	input logic               core1_ack_i,
	input node_pkg::bus_rsp_t core1_rsp_i
);

	// ==============================
	// Core 0 port
	// ==============================

	// ack_o changes at edge 5 and is first sampled high at edge 6
	core0_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$rose(core0_req_i) |-> ##6 $rose(core0_ack_i))
		else $error("core 0 ack_o did not rise 5 edges after req_i");

	core0_release: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		core0_ack_i && !core0_req_i |=> !core0_ack_i)
		else $error("core 0 ack_o stayed high after req_i fell");

	core0_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		core0_ack_i && $past(core0_ack_i) |-> $stable(core0_rsp_i))
		else $error("core 0 rsp_o changed while ack_o was high");

	// ==============================
	// Core 1 port
	// ==============================

	core1_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$rose(core1_req_i) |-> ##6 $rose(core1_ack_i))
		else $error("core 1 ack_o did not rise 5 edges after req_i");

	core1_release: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		core1_ack_i && !core1_req_i |=> !core1_ack_i)
		else $error("core 1 ack_o stayed high after req_i fell");

	core1_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		core1_ack_i && $past(core1_ack_i) |-> $stable(core1_rsp_i))
		else $error("core 1 rsp_o changed while ack_o was high");

	// Both ports stay quiet for as long as reset is held
	reset_quiet: assert property (@(posedge clk_i)
		!arst_n_i |-> !core0_ack_i && !core1_ack_i)
		else $error("ack_o high during reset");

endmodule

bind mem_node mem_node_properties props (
	.clk_i(clk_i), .arst_n_i(arst_n_i),
	.core0_req_i(core0_req_i), .core0_ack_i(core0_ack_o), .core0_rsp_i(core0_rsp_o),
	.core1_req_i(core1_req_i), .core1_ack_i(core1_ack_o), .core1_rsp_i(core1_rsp_o)
);

// File: node_pkg.sv
package node_pkg;

	// ==============================
	// Bus widths
	// ==============================

	localparam int ADDR_W = 32; // Byte address width seen by a core
	localparam int DATA_W = 32; // Width of one bus word
	localparam int BYTES  = DATA_W / 8; // Byte lanes in a word

	typedef logic [ADDR_W-1:0] addr_t; // Byte address from a core
	typedef logic [DATA_W-1:0] data_t; // Bus data word
	typedef logic [BYTES-1:0]  sel_t; // Byte-lane enables

	// The upper address bits pick the region like the old node decoder did
	localparam int REGION_MSB = 31;
	localparam int REGION_LSB = 18;
	localparam int WORD_LSB   = 2; // First byte-address bit of the word index

	typedef logic [REGION_MSB:REGION_LSB] region_field_t; // Raw region bits of an address

	// ==============================
	// Enumerations
	// ==============================

	typedef enum logic [1:0] {
		REGION_SHARED   = 2'd0, // Dual-port RAM seen by both cores
		REGION_SCRATCH  = 2'd1, // Private scratchpad of the requesting core
		REGION_UNMAPPED = 2'd2 // Anything else answers with err
	} region_t;

	// Four-phase handshake states of a core port
	typedef enum logic [1:0] {
		IDLE = 2'd0, // Waiting for a fresh req
		BUSY = 2'd1, // Access in flight inside the node
		ACK  = 2'd2 // Response held until req drops
	} port_state_t;

	// ==============================
	// Bundles
	// ==============================

	// What a core presents while req is high
	typedef struct packed {
		logic  we;
		sel_t  sel;
		addr_t adr;
		data_t dat;
	} bus_req_t;

	// What the node returns alongside ack
	typedef struct packed {
		data_t dat;
		logic  err;
	} bus_rsp_t;

	// Command into a RAM, idx is a word index and each RAM keeps only its low bits
	typedef struct packed {
		logic  we;
		sel_t  sel;
		addr_t idx;
		data_t dat;
	} mem_cmd_t;

endpackage

// File: region_decode.sv
`timescale 1ns/1ps

module region_decode #(
	parameter int SHARED_AW  = 15,
	parameter int SCRATCH_AW = 13
) (
	input  logic               clk_i,
	input  logic               arst_n_i,
	input  logic               cmd_valid_i,
	input  node_pkg::bus_req_t cmd_i,
	// Issue side, one strobe per RAM and a common command
	output logic               shared_valid_o,
	output logic               scratch_valid_o,
	output node_pkg::mem_cmd_t mem_cmd_o,
	// Read data coming back two cycles after the strobe
	input  logic               shared_rd_valid_i,
	input  node_pkg::data_t    shared_rd_i,
	input  logic               scratch_rd_valid_i,
	input  node_pkg::data_t    scratch_rd_i,
	// Response toward the port
	output logic               rsp_valid_o,
	output node_pkg::bus_rsp_t rsp_o
);

	// Word index bits a RAM actually decodes, higher bits alias
	localparam node_pkg::addr_t SHARED_MASK  = node_pkg::addr_t'(2**SHARED_AW - 1);
	localparam node_pkg::addr_t SCRATCH_MASK = node_pkg::addr_t'(2**SCRATCH_AW - 1);

	node_pkg::region_field_t field;
	node_pkg::region_t       region;
	node_pkg::addr_t         word_idx;

	node_pkg::region_t issue_region_q; // Region of the access at the RAM strobe
	node_pkg::region_t d1_region_q; // In step with the RAM array register
	node_pkg::region_t d2_region_q; // In step with the RAM output register
	logic              issue_valid_q;
	logic              d1_valid_q;
	logic              d2_valid_q;
	logic              d2_err_q; // Unmapped access reaches the response stage

	assign field    = cmd_i.adr[node_pkg::REGION_MSB:node_pkg::REGION_LSB];
	assign word_idx = cmd_i.adr >> node_pkg::WORD_LSB;

	always_comb begin
		if (field == node_pkg::region_field_t'(0)) begin
			region = node_pkg::REGION_SHARED;
		end else if (field == node_pkg::region_field_t'(1)) begin
			region = node_pkg::REGION_SCRATCH;
		end else begin
			region = node_pkg::REGION_UNMAPPED; // Former network controller window
		end
	end

	// ==============================
	// Issue stage and delay line
	// ==============================

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			shared_valid_o  <= 1'b0;
			scratch_valid_o <= 1'b0;
			issue_valid_q   <= 1'b0;
			issue_region_q  <= node_pkg::REGION_UNMAPPED;
			d1_valid_q      <= 1'b0;
			d1_region_q     <= node_pkg::REGION_UNMAPPED;
			d2_valid_q      <= 1'b0;
			d2_region_q     <= node_pkg::REGION_UNMAPPED;
			d2_err_q        <= 1'b0;
		end else begin
			// Only the matching RAM sees a strobe, unmapped strobes nothing
			shared_valid_o  <= cmd_valid_i && (region == node_pkg::REGION_SHARED);
			scratch_valid_o <= cmd_valid_i && (region == node_pkg::REGION_SCRATCH);
			issue_valid_q   <= cmd_valid_i;
			if (cmd_valid_i) begin
				issue_region_q <= region;
			end
			d1_valid_q  <= issue_valid_q; // Matches the RAM array stage
			d1_region_q <= issue_region_q;
			d2_valid_q  <= d1_valid_q; // Matches the RAM output stage
			d2_region_q <= d1_region_q;
			d2_err_q    <= d1_valid_q && (d1_region_q == node_pkg::REGION_UNMAPPED);
		end
	end

	// Command payload toward the RAMs, word index already folded to the RAM size
	always_ff @(posedge clk_i) begin
		if (cmd_valid_i) begin
			mem_cmd_o.we  <= cmd_i.we;
			mem_cmd_o.sel <= cmd_i.sel;
			mem_cmd_o.dat <= cmd_i.dat;
			if (region == node_pkg::REGION_SHARED) begin
				mem_cmd_o.idx <= word_idx & SHARED_MASK;
			end else begin
				mem_cmd_o.idx <= word_idx & SCRATCH_MASK;
			end
		end
	end

	// Gather the returning word from whichever source the access went to
	always_comb begin
		rsp_o.err = d2_err_q;
		case (d2_region_q)
			node_pkg::REGION_SHARED: begin
				rsp_valid_o = d2_valid_q && shared_rd_valid_i;
				rsp_o.dat   = shared_rd_i;
			end
			node_pkg::REGION_SCRATCH: begin
				rsp_valid_o = d2_valid_q && scratch_rd_valid_i;
				rsp_o.dat   = scratch_rd_i;
			end
			default: begin
				rsp_valid_o = d2_valid_q; // Same latency as a RAM access
				rsp_o.dat   = '0;
			end
		endcase
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mem_node -f vlog.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -x "Done: no errors" > /dev/null \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }

// File: scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram #(
	parameter int SCRATCH_AW = 13
) (
	input  logic               clk_i,
	input  logic               arst_n_i,
	input  logic               valid_i,
	input  node_pkg::mem_cmd_t cmd_i,
	output logic               rd_valid_o,
	output node_pkg::data_t    rd_o
);

	node_pkg::data_t mem [2**SCRATCH_AW];

	logic [SCRATCH_AW-1:0] idx; // Word index within the scratchpad
	node_pkg::data_t       arr_q; // Array read register
	logic                  v1_q;

	assign idx = cmd_i.idx[SCRATCH_AW-1:0];

	always_ff @(posedge clk_i) begin
		for (int i = 0; i < node_pkg::BYTES; i++) begin
			if (valid_i && cmd_i.we && cmd_i.sel[i]) begin
				mem[idx][8*i +: 8] <= cmd_i.dat[8*i +: 8];
			end
		end
		if (valid_i) begin
			arr_q <= mem[idx]; // Read first behaviour
		end
	end

	// Output stage lines up with the valid pipeline
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			v1_q       <= 1'b0;
			rd_valid_o <= 1'b0;
			rd_o       <= '0;
		end else begin
			v1_q       <= valid_i;
			rd_valid_o <= v1_q;
			if (v1_q) begin
				rd_o <= arr_q;
			end
		end
	end

endmodule

// File: shared_ram.sv
`timescale 1ns/1ps

module shared_ram #(
	parameter int SHARED_AW = 15
) (
	input  logic               clk_i,
	input  logic               arst_n_i,
	// Port a belongs to core 0
	input  logic               a_valid_i,
	input  node_pkg::mem_cmd_t a_cmd_i,
	output logic               a_rd_valid_o,
	output node_pkg::data_t    a_rd_o,
	// Port b belongs to core 1
	input  logic               b_valid_i,
	input  node_pkg::mem_cmd_t b_cmd_i,
	output logic               b_rd_valid_o,
	output node_pkg::data_t    b_rd_o
);

	node_pkg::data_t mem [2**SHARED_AW];

	logic [SHARED_AW-1:0] a_idx; // Upper index bits alias onto these
	logic [SHARED_AW-1:0] b_idx;
	logic                 a_wr;
	logic                 b_wr;
	node_pkg::data_t      a_arr_q; // First read stage
	node_pkg::data_t      b_arr_q;
	logic                 a_v1_q;
	logic                 b_v1_q;

	assign a_idx = a_cmd_i.idx[SHARED_AW-1:0];
	assign b_idx = b_cmd_i.idx[SHARED_AW-1:0];
	assign a_wr  = a_valid_i && a_cmd_i.we;
	assign b_wr  = b_valid_i && b_cmd_i.we;

	// ==============================
	// Storage
	// ==============================

	always_ff @(posedge clk_i) begin
		for (int i = 0; i < node_pkg::BYTES; i++) begin
			if (b_wr && b_cmd_i.sel[i]) begin
				mem[b_idx][8*i +: 8] <= b_cmd_i.dat[8*i +: 8];
			end
			// Port a comes last so it wins a lane both ports write
			if (a_wr && a_cmd_i.sel[i]) begin
				mem[a_idx][8*i +: 8] <= a_cmd_i.dat[8*i +: 8];
			end
		end
		if (a_valid_i) begin
			a_arr_q <= mem[a_idx]; // Old contents on a same cycle write
		end
		if (b_valid_i) begin
			b_arr_q <= mem[b_idx];
		end
	end

	// Output register and valid pipeline for both ports
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			a_v1_q       <= 1'b0;
			b_v1_q       <= 1'b0;
			a_rd_valid_o <= 1'b0;
			b_rd_valid_o <= 1'b0;
			a_rd_o       <= '0;
			b_rd_o       <= '0;
		end else begin
			a_v1_q       <= a_valid_i;
			b_v1_q       <= b_valid_i;
			a_rd_valid_o <= a_v1_q; // Second cycle after the strobe
			b_rd_valid_o <= b_v1_q;
			if (a_v1_q) begin
				a_rd_o <= a_arr_q;
			end
			if (b_v1_q) begin
				b_rd_o <= b_arr_q;
			end
		end
	end

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
	input  logic               clk_i,
	input  logic               arst_n_i,
	input  logic               core0_req_i,
	input  logic               core0_ack_i,
	input  node_pkg::bus_rsp_t core0_rsp_i,
	input  node_pkg::bus_rsp_t core0_want_i, // Expected response from the table
	input  logic               core0_chk_i, // Data is compared only when set
	input  logic               core1_req_i,
	input  logic               core1_ack_i,
	input  node_pkg::bus_rsp_t core1_rsp_i,
	input  node_pkg::bus_rsp_t core1_want_i,
	input  logic               core1_chk_i,
	input  logic [7:0]         test_i,
	input  logic               test_done_i, // Last access of a test has finished
	input  logic               run_done_i,
	output int                 err_count_o
);

	logic ack0_q; // Previous ack_o values find the rising edge
	logic ack1_q;
	int   checks      = 0;
	int   errors      = 0;
	int   test_checks = 0;
	int   test_errors = 0;

	assign err_count_o = errors;

	task automatic compare_rsp(input int core, input node_pkg::bus_rsp_t got,
			input node_pkg::bus_rsp_t want, input logic chk_dat);
		checks++;
		test_checks++;
		if (got.err !== want.err) begin
			$display("FAILED test %0d core%0d_rsp_o.err got %h expected %h",
				test_i, core, got.err, want.err);
			errors++;
			test_errors++;
		end
		if (chk_dat && (got.dat !== want.dat)) begin
			$display("FAILED test %0d core%0d_rsp_o.dat got %h expected %h",
				test_i, core, got.dat, want.dat);
			errors++;
			test_errors++;
		end
	endtask

	// An ack with req low means a response nobody asked for
	task automatic stray_ack(input int core);
		$display("Core %0d raised ack_o in test %0d with no request pending", core, test_i);
		errors++;
		test_errors++;
	endtask

	// ==============================
	// Response watch
	// ==============================

	always @(posedge clk_i) begin
		ack0_q <= core0_ack_i;
		ack1_q <= core1_ack_i;
		if (arst_n_i) begin
			if (core0_ack_i && !ack0_q) begin
				if (core0_req_i) begin
					compare_rsp(0, core0_rsp_i, core0_want_i, core0_chk_i);
				end else begin
					stray_ack(0);
				end
			end
			if (core1_ack_i && !ack1_q) begin
				if (core1_req_i) begin
					compare_rsp(1, core1_rsp_i, core1_want_i, core1_chk_i);
				end else begin
					stray_ack(1);
				end
			end
			if (test_done_i) begin
				$display("Test %0d %s with %0d checks and %0d errors", test_i,
					(test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
				test_checks = 0;
				test_errors = 0;
			end
			if (run_done_i) begin
				$display("Total of %0d checks and %0d errors", checks, errors);
			end
		end
	end

endmodule

// File: tb_mem_node.sv
`timescale 1ns/1ps

module tb_mem_node;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 8;
	localparam int SHARED_AW    = 15; // Same as the defaults of dut0
	localparam int SCRATCH_AW   = 13;

	// A byte offset of one full RAM span lands on the same word again
	localparam node_pkg::addr_t SHARED_WRAP  = node_pkg::addr_t'(2**(SHARED_AW + 2));
	localparam node_pkg::addr_t SCRATCH_WRAP = node_pkg::addr_t'(2**(SCRATCH_AW + 2));
	localparam node_pkg::addr_t SB           = 32'h0004_0000; // Start of region 1

	typedef struct packed {
		node_pkg::bus_req_t req; // What the core drives while req is high
		node_pkg::bus_rsp_t want; // Response the node must return
		logic               chk; // Data is defined for reads and for errors only
	} core_op_t;

	typedef struct packed {
		logic [7:0] test;
		logic [1:0] mask; // Bit 0 is core 0 and bit 1 is core 1
		core_op_t   op0;
		core_op_t   op1;
	} entry_t;

	localparam core_op_t NO_OP = '0;

	logic               clk;
	logic               arst_n;
	logic               core0_req;
	logic               core0_ack;
	node_pkg::bus_req_t core0_bus;
	node_pkg::bus_rsp_t core0_rsp;
	logic               core1_req;
	logic               core1_ack;
	node_pkg::bus_req_t core1_bus;
	node_pkg::bus_rsp_t core1_rsp;

	entry_t          cur; // Entry in flight, its expected values go to the checker
	entry_t          tbl [$];
	node_pkg::data_t rnd [13];
	logic            test_done;
	logic            run_done;
	logic            table_ready;
	logic            last_of_test;
	int              err_count;
	int              seed;
	int              limit_ns;

	always #(CLK_PERIOD / 2) clk = ~clk;

	mem_node dut0 (
		.clk_i(clk), .arst_n_i(arst_n),
		.core0_req_i(core0_req), .core0_ack_o(core0_ack),
		.core0_bus_i(core0_bus), .core0_rsp_o(core0_rsp),
		.core1_req_i(core1_req), .core1_ack_o(core1_ack),
		.core1_bus_i(core1_bus), .core1_rsp_o(core1_rsp)
	);

	tb_checker chk (
		.clk_i(clk), .arst_n_i(arst_n),
		.core0_req_i(core0_req), .core0_ack_i(core0_ack), .core0_rsp_i(core0_rsp),
		.core0_want_i(cur.op0.want), .core0_chk_i(cur.op0.chk),
		.core1_req_i(core1_req), .core1_ack_i(core1_ack), .core1_rsp_i(core1_rsp),
		.core1_want_i(cur.op1.want), .core1_chk_i(cur.op1.chk),
		.test_i(cur.test), .test_done_i(test_done), .run_done_i(run_done),
		.err_count_o(err_count)
	);

	// ==============================
	// Table building
	// ==============================

	function automatic core_op_t make_op(input logic we, input node_pkg::sel_t sel,
			input node_pkg::addr_t adr, input node_pkg::data_t dat, input logic chk,
			input node_pkg::data_t want_dat, input logic want_err);
		core_op_t op;
		op.req.we   = we;
		op.req.sel  = sel;
		op.req.adr  = adr;
		op.req.dat  = dat;
		op.want.dat = want_dat;
		op.want.err = want_err;
		op.chk      = chk;
		return op;
	endfunction

	function automatic core_op_t write_op(input node_pkg::addr_t adr, input node_pkg::sel_t sel,
			input node_pkg::data_t dat);
		return make_op(1'b1, sel, adr, dat, 1'b0, 32'h0, 1'b0); // Write data returned is don't-care
	endfunction

	function automatic core_op_t read_op(input node_pkg::addr_t adr, input node_pkg::data_t want);
		return make_op(1'b0, 4'hf, adr, 32'h0, 1'b1, want, 1'b0);
	endfunction

	// Unmapped accesses answer err with a zero word, reads and writes alike
	function automatic core_op_t bad_op(input logic we, input node_pkg::addr_t adr,
			input node_pkg::data_t dat);
		return make_op(we, 4'hf, adr, dat, 1'b1, 32'h0, 1'b1);
	endfunction

	// Lanes with sel set take the new byte and the rest keep the old one
	function automatic node_pkg::data_t lane_merge(input node_pkg::data_t old_w,
			input node_pkg::data_t new_w, input node_pkg::sel_t sel);
		node_pkg::data_t res;
		res = old_w;
		for (int i = 0; i < node_pkg::BYTES; i++) begin
			if (sel[i]) begin
				res[8*i +: 8] = new_w[8*i +: 8];
			end
		end
		return res;
	endfunction

	task automatic add_entry(input logic [7:0] test, input logic [1:0] mask,
			input core_op_t op0, input core_op_t op1);
		entry_t e;
		e.test = test;
		e.mask = mask;
		e.op0  = op0;
		e.op1  = op1;
		tbl.push_back(e);
	endtask

	task automatic fill_table();
		node_pkg::data_t m_sh; // Shared word after the partial write
		node_pkg::data_t m_sp; // Scratch word after the partial write
		foreach (rnd[k]) begin
			rnd[k] = $random(seed);
		end
		m_sh = lane_merge(rnd[4], rnd[5], 4'h5);
		m_sp = lane_merge(rnd[6], rnd[7], 4'h5);
		add_entry(8'd1, 2'b01, write_op(32'h100, 4'hf, rnd[0]), NO_OP); // First access after reset
		add_entry(8'd1, 2'b01, read_op(32'h100, rnd[0]), NO_OP);
		// Core 1 sees what core 0 left in the shared RAM
		add_entry(8'd2, 2'b01, write_op(32'h200, 4'hf, rnd[1]), NO_OP);
		add_entry(8'd2, 2'b10, NO_OP, read_op(32'h200, rnd[1]));
		add_entry(8'd2, 2'b11, write_op(32'h300, 4'hf, rnd[2]), write_op(32'h300, 4'hf, rnd[3]));
		add_entry(8'd2, 2'b11, read_op(32'h300, rnd[2]), read_op(32'h300, rnd[2])); // Core 0 won
		add_entry(8'd3, 2'b01, write_op(32'h400, 4'hf, rnd[4]), NO_OP);
		add_entry(8'd3, 2'b01, write_op(32'h400, 4'h5, rnd[5]), NO_OP);
		add_entry(8'd3, 2'b01, read_op(32'h400, m_sh), NO_OP);
		add_entry(8'd3, 2'b10, NO_OP, write_op(SB + 32'h400, 4'hf, rnd[6]));
		add_entry(8'd3, 2'b10, NO_OP, write_op(SB + 32'h400, 4'h5, rnd[7]));
		add_entry(8'd3, 2'b10, NO_OP, read_op(SB + 32'h400, m_sp));
		// Same scratch address on both cores reaches two separate RAMs
		add_entry(8'd4, 2'b11, write_op(SB + 32'h800, 4'hf, rnd[8]),
			write_op(SB + 32'h800, 4'hf, rnd[9]));
		add_entry(8'd4, 2'b11, read_op(SB + 32'h800, rnd[8]), read_op(SB + 32'h800, rnd[9]));
		// Regions 2 and 3 whose low bits point at the words written in test 3
		add_entry(8'd5, 2'b11, bad_op(1'b1, 32'h0008_0400, rnd[10]),
			bad_op(1'b1, 32'h000c_0400, rnd[10]));
		add_entry(8'd5, 2'b11, bad_op(1'b0, 32'hffff_fffc, 32'h0),
			bad_op(1'b0, 32'h0008_0400, 32'h0));
		add_entry(8'd5, 2'b01, read_op(32'h400, m_sh), NO_OP);
		add_entry(8'd5, 2'b10, NO_OP, read_op(SB + 32'h400, m_sp));
		add_entry(8'd6, 2'b01, write_op(32'h500 + SHARED_WRAP, 4'hf, rnd[11]), NO_OP);
		add_entry(8'd6, 2'b10, NO_OP, read_op(32'h500, rnd[11]));
		add_entry(8'd6, 2'b10, NO_OP, write_op(SB + 32'h600 + SCRATCH_WRAP, 4'hf, rnd[12]));
		add_entry(8'd6, 2'b10, NO_OP, read_op(SB + 32'h600, rnd[12]));
	endtask

	// ==============================
	// Drive loop
	// ==============================

	// One four-phase access on every core in the mask
	task automatic run_entry(input entry_t e, input logic last);
		cur       <= e;
		core0_bus <= e.op0.req;
		core1_bus <= e.op1.req;
		core0_req <= e.mask[0];
		core1_req <= e.mask[1];
		do begin
			@(posedge clk);
		end while (!((core0_ack || !e.mask[0]) && (core1_ack || !e.mask[1])));
		core0_req <= 1'b0;
		core1_req <= 1'b0;
		do begin
			@(posedge clk);
		end while (core0_ack || core1_ack); // Next request only once ack is seen low
		if (last) begin
			test_done <= 1'b1;
			@(posedge clk);
			test_done <= 1'b0;
		end
	endtask

	initial begin
		clk         = 1'b0;
		arst_n      = 1'b0;
		core0_req   = 1'b0;
		core1_req   = 1'b0;
		core0_bus   = '0;
		core1_bus   = '0;
		cur         = '0;
		test_done   = 1'b0;
		run_done    = 1'b0;
		table_ready = 1'b0;
		seed        = 32'hd60b;
		fill_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		repeat (4) @(posedge clk); // Idle cycles where no ack_o may show up
		foreach (tbl[i]) begin
			last_of_test = (i + 1 >= tbl.size()) ? 1'b1 : (tbl[i + 1].test != tbl[i].test);
			run_entry(tbl[i], last_of_test);
		end
		run_done <= 1'b1;
		@(posedge clk);
		run_done <= 1'b0;
		@(posedge clk);
		if (err_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Watchdog sized from the reset and the table length
	initial begin
		wait (table_ready);
		limit_ns = (RESET_CYCLES + tbl.size() * 12) * CLK_PERIOD;
		#(limit_ns);
		$display("Timed out after %0d ns before all tests finished", limit_ns);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: vlog.f
node_pkg.sv
bus_port.sv
region_decode.sv
shared_ram.sv
scratch_ram.sv
mem_node.sv
mem_node_properties.sv
tb_checker.sv
tb_mem_node.sv
